//--- rtl/border_settings.svh
`ifndef BORDER_SETTINGS_SVH
`define BORDER_SETTINGS_SVH

// bits per lattice coordinate
`define PER_DIMENSION_WIDTH 3

// cost of the cut edge in growth steps
`define LINK_LENGTH 2

// growth count, wide enough to hold LINK_LENGTH
`define GROWN_WIDTH 2

// entries per blocking-channel buffer
`define DIRECT_FIFO_DEPTH 8

// route header on the master FIFO
`define HEADER_WIDTH 6

// header values of the two traffic kinds
`define ROUTE_ID_NEIGHBOR 6'd9
`define ROUTE_ID_DIRECT 6'd10

`endif

//--- rtl/border_pkg.sv
`include "border_settings.svh"

package border_pkg;

    // decoder stage as driven by the controller
    typedef enum logic [2:0] {
        IDLE                = 3'd0,
        MEASUREMENT_LOADING = 3'd1,
        GROW                = 3'd2,
        MERGE               = 3'd3
    } stage_e;

    // lattice coordinate of a processing unit
    typedef struct packed {
        logic [`PER_DIMENSION_WIDTH-1:0] i;
        logic [`PER_DIMENSION_WIDTH-1:0] j;
        logic [`PER_DIMENSION_WIDTH-1:0] k;
    } address_t;

    // state shared across the cut edge
    typedef struct packed {
        address_t                root;
        logic                    is_odd_cluster;
        logic [`GROWN_WIDTH-1:0] grown;
    } neighbor_msg_t;

    // blocking message addressed to a root
    typedef struct packed {
        address_t receiver;
        logic     is_odd_cardinality_root;
        logic     is_touching_boundary;
        logic     reserved;
    } direct_msg_t;

    // one payload word, read as either kind
    typedef union packed {
        neighbor_msg_t nbr;
        direct_msg_t   dir;
    } payload_u;

    // word on the master FIFO
    typedef struct packed {
        logic [`HEADER_WIDTH-1:0] header;
        logic                     is_direct;
        payload_u                 payload;
    } master_word_t;

endpackage

//--- rtl/neighbor_link_port.sv
`timescale 1ns/100ps

`include "border_settings.svh"

module neighbor_link_port
    import border_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  stage_e        stage_i,
    input  address_t      local_root_i,
    input  logic          local_is_odd_cluster_i,
    input  logic          increase_i,
    output neighbor_msg_t nbr_tx_o,
    output logic          nbr_tx_valid_o,
    input  logic          nbr_tx_ready_i,
    input  neighbor_msg_t nbr_rx_i,
    input  logic          nbr_rx_valid_i,
    output address_t      remote_root_o,
    output logic          remote_is_odd_cluster_o,
    output logic          is_fully_grown_o,
    output logic          initialize_o
);

    stage_e                  stage_q;
    logic [`GROWN_WIDTH-1:0] local_grown_q;
    logic [`GROWN_WIDTH-1:0] remote_grown_q;
    logic [`GROWN_WIDTH:0]   grown_sum;
    neighbor_msg_t           current_state;
    neighbor_msg_t           last_sent_q;
    logic                    state_changed;

    // registered stage, the PU sees it one cycle late as well
    always_ff @(posedge clk) begin
        if (reset) begin
            stage_q <= IDLE;
        end else begin
            stage_q <= stage_i;
        end
    end

    assign initialize_o = (stage_q == MEASUREMENT_LOADING);

    // local growth, saturating at the edge length
    always_ff @(posedge clk) begin
        if (reset || initialize_o) begin
            local_grown_q <= '0;
        end else if (stage_q == GROW && increase_i && local_grown_q < `LINK_LENGTH) begin
            local_grown_q <= local_grown_q + 1'b1;
        end
    end

    assign current_state.root           = local_root_i;
    assign current_state.is_odd_cluster = local_is_odd_cluster_i;
    assign current_state.grown          = local_grown_q;

    assign state_changed = (current_state != last_sent_q);

    // send only on change; a newer state replaces a pending one
    always_ff @(posedge clk) begin
        if (reset || initialize_o) begin
            last_sent_q    <= '0;
            nbr_tx_valid_o <= 1'b0;
        end else if (state_changed) begin
            last_sent_q    <= current_state;
            nbr_tx_valid_o <= 1'b1;
        end else if (nbr_tx_valid_o && nbr_tx_ready_i) begin
            nbr_tx_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (state_changed) begin
            nbr_tx_o <= current_state;
        end
    end

    // state of the other side of the cut
    always_ff @(posedge clk) begin
        if (reset || initialize_o) begin
            remote_root_o           <= '0;
            remote_is_odd_cluster_o <= 1'b0;
            remote_grown_q          <= '0;
        end else if (nbr_rx_valid_i) begin
            remote_root_o           <= nbr_rx_i.root;
            remote_is_odd_cluster_o <= nbr_rx_i.is_odd_cluster;
            remote_grown_q          <= nbr_rx_i.grown;
        end
    end

    assign grown_sum = {1'b0, local_grown_q} + {1'b0, remote_grown_q};

    // edge is covered once both halves together reach its length
    always_ff @(posedge clk) begin
        if (reset || initialize_o) begin
            is_fully_grown_o <= 1'b0;
        end else begin
            is_fully_grown_o <= (grown_sum >= `LINK_LENGTH);
        end
    end

endmodule

//--- rtl/direct_channel_fifo.sv
`timescale 1ns/100ps

`include "border_settings.svh"

module direct_channel_fifo
    import border_pkg::*;
#(
    parameter int DEPTH = `DIRECT_FIFO_DEPTH
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        initialize_i,
    input  direct_msg_t in_data_i,
    input  logic        in_valid_i,
    output logic        in_is_full_o,
    output direct_msg_t out_data_o,
    output logic        out_valid_o,
    input  logic        out_is_taken_i
);

    localparam int PTR_WIDTH = $clog2(DEPTH);
    localparam int COUNT_WIDTH = $clog2(DEPTH + 1);

    direct_msg_t            mem [DEPTH];
    logic [PTR_WIDTH-1:0]   wr_ptr_q;
    logic [PTR_WIDTH-1:0]   rd_ptr_q;
    logic [COUNT_WIDTH-1:0] count_q;
    logic                   push;
    logic                   pop;

    assign in_is_full_o = (count_q == COUNT_WIDTH'(DEPTH));
    assign out_valid_o  = (count_q != '0);
    // head is visible without a read request
    assign out_data_o   = mem[rd_ptr_q];

    assign push = in_valid_i && !in_is_full_o;
    assign pop  = out_valid_o && out_is_taken_i;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr_q] <= in_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || initialize_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_WIDTH'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_WIDTH'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            // simultaneous push and pop leaves the count alone
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

endmodule

//--- rtl/master_fifo_arbiter.sv
`timescale 1ns/100ps

`include "border_settings.svh"

module master_fifo_arbiter
    import border_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  neighbor_msg_t nbr_tx_i,
    input  logic          nbr_tx_valid_i,
    output logic          nbr_tx_ready_o,
    input  direct_msg_t   dir_tx_i,
    input  logic          dir_tx_valid_i,
    output logic          dir_tx_taken_o,
    output neighbor_msg_t nbr_rx_o,
    output logic          nbr_rx_valid_o,
    output direct_msg_t   dir_rx_o,
    output logic          dir_rx_valid_o,
    input  logic          dir_rx_full_i,
    input  logic          dir_rx_pending_i,
    output master_word_t  master_out_data_o,
    output logic          master_out_valid_o,
    input  logic          master_out_ready_i,
    input  master_word_t  master_in_data_i,
    input  logic          master_in_valid_i,
    output logic          master_in_ready_o,
    output logic          has_message_flying_o
);

    logic         load_en;
    logic         grant_dir;
    logic         grant_nbr;
    logic         last_grant_dir_q;
    payload_u     tx_payload;
    master_word_t tx_word;
    logic         in_fire;

    // output register free, or emptied this cycle
    assign load_en = !master_out_valid_o || master_out_ready_i;

    // on contention, the source not served last time wins
    assign grant_dir = dir_tx_valid_i && (!nbr_tx_valid_i || !last_grant_dir_q);
    assign grant_nbr = nbr_tx_valid_i && !grant_dir;

    assign nbr_tx_ready_o = load_en && grant_nbr;
    assign dir_tx_taken_o = load_en && grant_dir;

    always_comb begin
        if (grant_dir) begin
            tx_payload.dir = dir_tx_i;
        end else begin
            tx_payload.nbr = nbr_tx_i;
        end
    end

    assign tx_word.header    = grant_dir ? `ROUTE_ID_DIRECT : `ROUTE_ID_NEIGHBOR;
    assign tx_word.is_direct = grant_dir;
    assign tx_word.payload   = tx_payload;

    always_ff @(posedge clk) begin
        if (reset) begin
            master_out_valid_o <= 1'b0;
            last_grant_dir_q   <= 1'b0;
        end else if (load_en) begin
            master_out_valid_o <= grant_dir || grant_nbr;
            if (grant_dir || grant_nbr) begin
                last_grant_dir_q <= grant_dir;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_en && (grant_dir || grant_nbr)) begin
            master_out_data_o <= tx_word;
        end
    end

    // receive side, header is not checked
    assign master_in_ready_o = !dir_rx_full_i;
    assign in_fire           = master_in_valid_i && master_in_ready_o;

    assign nbr_rx_o       = master_in_data_i.payload.nbr;
    assign nbr_rx_valid_o = in_fire && !master_in_data_i.is_direct;
    assign dir_rx_o       = master_in_data_i.payload.dir;
    assign dir_rx_valid_o = in_fire && master_in_data_i.is_direct;

    // anything still queued or on the wire
    always_ff @(posedge clk) begin
        if (reset) begin
            has_message_flying_o <= 1'b0;
        end else begin
            has_message_flying_o <= nbr_tx_valid_i || dir_tx_valid_i ||
                                    dir_rx_pending_i || master_out_valid_o;
        end
    end

endmodule

//--- rtl/partition_border_bridge.sv
`timescale 1ns/100ps

module partition_border_bridge
    import border_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  stage_e       stage_i,
    input  address_t     local_root_i,
    input  logic         local_is_odd_cluster_i,
    input  logic         increase_i,
    output address_t     remote_root_o,
    output logic         remote_is_odd_cluster_o,
    output logic         is_fully_grown_o,
    input  direct_msg_t  direct_in_data_i,
    input  logic         direct_in_valid_i,
    output logic         direct_in_is_full_o,
    output direct_msg_t  direct_out_data_o,
    output logic         direct_out_valid_o,
    input  logic         direct_out_is_taken_i,
    output master_word_t master_out_data_o,
    output logic         master_out_valid_o,
    input  logic         master_out_ready_i,
    input  master_word_t master_in_data_i,
    input  logic         master_in_valid_i,
    output logic         master_in_ready_o,
    output logic         has_message_flying_o
);

    neighbor_msg_t nbr_tx;
    logic          nbr_tx_valid;
    logic          nbr_tx_ready;
    neighbor_msg_t nbr_rx;
    logic          nbr_rx_valid;
    direct_msg_t   dir_tx_data;
    logic          dir_tx_valid;
    logic          dir_tx_taken;
    direct_msg_t   dir_rx_data;
    logic          dir_rx_valid;
    logic          dir_rx_full;
    logic          initialize;

    neighbor_link_port u_neighbor_link_port (
        .clk                     (clk),
        .reset                   (reset),
        .stage_i                 (stage_i),
        .local_root_i            (local_root_i),
        .local_is_odd_cluster_i  (local_is_odd_cluster_i),
        .increase_i              (increase_i),
        .nbr_tx_o                (nbr_tx),
        .nbr_tx_valid_o          (nbr_tx_valid),
        .nbr_tx_ready_i          (nbr_tx_ready),
        .nbr_rx_i                (nbr_rx),
        .nbr_rx_valid_i          (nbr_rx_valid),
        .remote_root_o           (remote_root_o),
        .remote_is_odd_cluster_o (remote_is_odd_cluster_o),
        .is_fully_grown_o        (is_fully_grown_o),
        .initialize_o            (initialize)
    );

    // PU to master FIFO
    direct_channel_fifo u_tx_fifo (
        .clk            (clk),
        .reset          (reset),
        .initialize_i   (initialize),
        .in_data_i      (direct_in_data_i),
        .in_valid_i     (direct_in_valid_i),
        .in_is_full_o   (direct_in_is_full_o),
        .out_data_o     (dir_tx_data),
        .out_valid_o    (dir_tx_valid),
        .out_is_taken_i (dir_tx_taken)
    );

    // master FIFO to PU
    direct_channel_fifo u_rx_fifo (
        .clk            (clk),
        .reset          (reset),
        .initialize_i   (initialize),
        .in_data_i      (dir_rx_data),
        .in_valid_i     (dir_rx_valid),
        .in_is_full_o   (dir_rx_full),
        .out_data_o     (direct_out_data_o),
        .out_valid_o    (direct_out_valid_o),
        .out_is_taken_i (direct_out_is_taken_i)
    );

    master_fifo_arbiter u_master_fifo_arbiter (
        .clk                  (clk),
        .reset                (reset),
        .nbr_tx_i             (nbr_tx),
        .nbr_tx_valid_i       (nbr_tx_valid),
        .nbr_tx_ready_o       (nbr_tx_ready),
        .dir_tx_i             (dir_tx_data),
        .dir_tx_valid_i       (dir_tx_valid),
        .dir_tx_taken_o       (dir_tx_taken),
        .nbr_rx_o             (nbr_rx),
        .nbr_rx_valid_o       (nbr_rx_valid),
        .dir_rx_o             (dir_rx_data),
        .dir_rx_valid_o       (dir_rx_valid),
        .dir_rx_full_i        (dir_rx_full),
        .dir_rx_pending_i     (direct_out_valid_o),
        .master_out_data_o    (master_out_data_o),
        .master_out_valid_o   (master_out_valid_o),
        .master_out_ready_i   (master_out_ready_i),
        .master_in_data_i     (master_in_data_i),
        .master_in_valid_i    (master_in_valid_i),
        .master_in_ready_o    (master_in_ready_o),
        .has_message_flying_o (has_message_flying_o)
    );

endmodule

//--- tests/tb_border_bridge.sv
`timescale 1ns/100ps

`include "border_settings.svh"

module tb_border_bridge
    import border_pkg::*;
();

    logic          clk;
    logic          reset;
    stage_e        stage;
    address_t      local_root;
    logic          local_is_odd;
    logic          increase;
    address_t      remote_root;
    logic          remote_is_odd;
    logic          is_fully_grown;
    direct_msg_t   direct_in_data;
    logic          direct_in_valid;
    logic          direct_in_is_full;
    direct_msg_t   direct_out_data;
    logic          direct_out_valid;
    logic          direct_out_is_taken = 1'b0;
    master_word_t  master_out_data;
    logic          master_out_valid;
    logic          master_out_ready;
    master_word_t  master_in_data;
    logic          master_in_valid;
    logic          master_in_ready;
    logic          has_message_flying;

    int            error_count = 0;
    int            seed = 32'hbf00;
    int            cycle_count = 0;
    direct_msg_t   tx_q[$];
    direct_msg_t   rx_q[$];
    neighbor_msg_t last_nbr = '0;
    neighbor_msg_t sent_nbr;
    master_word_t  prev_out;
    logic [`GROWN_WIDTH-1:0] exp_grown;

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    partition_border_bridge i_dut (
        .clk                     (clk),
        .reset                   (reset),
        .stage_i                 (stage),
        .local_root_i            (local_root),
        .local_is_odd_cluster_i  (local_is_odd),
        .increase_i              (increase),
        .remote_root_o           (remote_root),
        .remote_is_odd_cluster_o (remote_is_odd),
        .is_fully_grown_o        (is_fully_grown),
        .direct_in_data_i        (direct_in_data),
        .direct_in_valid_i       (direct_in_valid),
        .direct_in_is_full_o     (direct_in_is_full),
        .direct_out_data_o       (direct_out_data),
        .direct_out_valid_o      (direct_out_valid),
        .direct_out_is_taken_i   (direct_out_is_taken),
        .master_out_data_o       (master_out_data),
        .master_out_valid_o      (master_out_valid),
        .master_out_ready_i      (master_out_ready),
        .master_in_data_i        (master_in_data),
        .master_in_valid_i       (master_in_valid),
        .master_in_ready_o       (master_in_ready),
        .has_message_flying_o    (has_message_flying)
    );

    task automatic check_equal(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (expected == actual) else begin
            error_count++;
            $display("error %s: expected %h actual %h", name, expected, actual);
        end
    endtask

    function automatic address_t random_address();
        logic [31:0] r;
        r = $random(seed);
        return r[8:0];
    endfunction

    function automatic direct_msg_t random_direct();
        logic [31:0] r;
        r = $random(seed);
        return r[11:0];
    endfunction

    // what the far side should hold once everything has been sent
    function automatic neighbor_msg_t expected_neighbor();
        neighbor_msg_t state;
        state.root           = local_root;
        state.is_odd_cluster = local_is_odd;
        state.grown          = exp_grown;
        return state;
    endfunction

    task automatic push_direct(input direct_msg_t msg);
        int cycles;
        direct_in_data  <= msg;
        direct_in_valid <= 1'b1;
        for (cycles = 0; cycles < 100; cycles++) begin
            @(posedge clk);
            if (!direct_in_is_full) begin
                break;
            end
        end
        direct_in_valid <= 1'b0;
        if (cycles < 100) begin
            tx_q.push_back(msg);
        end else begin
            error_count++;
            $display("timeout: the direct channel input never accepted a message");
        end
    endtask

    task automatic send_master_word(input master_word_t word);
        int cycles;
        master_in_data  <= word;
        master_in_valid <= 1'b1;
        for (cycles = 0; cycles < 100; cycles++) begin
            @(posedge clk);
            if (master_in_ready) begin
                break;
            end
        end
        master_in_valid <= 1'b0;
        if (cycles >= 100) begin
            error_count++;
            $display("timeout: the bridge never accepted a word from the master FIFO");
        end
    endtask

    // quiet for a few cycles in a row, since the in-flight flag lags
    task automatic wait_drain(input string name);
        int cycles;
        int quiet;
        quiet = 0;
        for (cycles = 0; cycles < 300 && quiet < 4; cycles++) begin
            @(posedge clk);
            if (!has_message_flying && tx_q.size() == 0 && rx_q.size() == 0) begin
                quiet++;
            end else begin
                quiet = 0;
            end
        end
        if (quiet < 4) begin
            error_count++;
            $display("timeout in %s: traffic through the bridge did not drain", name);
        end
        check_equal({name, "_neighbor"}, expected_neighbor(), last_nbr);
    endtask

    task automatic load_stage();
        stage <= MEASUREMENT_LOADING;
        @(posedge clk);
        stage <= IDLE;
        exp_grown = '0;
    endtask

    // rx side is stalled one cycle in three
    always @(posedge clk) begin
        cycle_count++;
        direct_out_is_taken <= (cycle_count % 3 != 0);
        prev_out <= master_out_data;
    end

    // scoreboards on the master FIFO output and the direct channel output
    always @(posedge clk) begin
        if (!reset && master_out_valid && master_out_ready) begin
            if (master_out_data.is_direct) begin
                check_equal("direct_header", `ROUTE_ID_DIRECT, master_out_data.header);
                if (tx_q.size() == 0) begin
                    error_count++;
                    $display("an unexpected direct word left on the master FIFO");
                end else begin
                    check_equal("direct_tx", tx_q.pop_front(), master_out_data.payload.dir);
                end
            end else begin
                check_equal("neighbor_header", `ROUTE_ID_NEIGHBOR, master_out_data.header);
                last_nbr = master_out_data.payload.nbr;
            end
        end
        if (!reset && direct_out_valid && direct_out_is_taken) begin
            if (rx_q.size() == 0) begin
                error_count++;
                $display("the direct channel output showed a message that was never received");
            end else begin
                check_equal("direct_rx", rx_q.pop_front(), direct_out_data);
            end
        end
        if (!reset && master_in_valid && master_in_ready) begin
            if (master_in_data.is_direct) begin
                rx_q.push_back(master_in_data.payload.dir);
            end else begin
                sent_nbr <= master_in_data.payload.nbr;
            end
        end
    end

    stable_out: assert property (@(posedge clk) disable iff (reset)
        master_out_valid && !master_out_ready |=> master_out_valid && master_out_data == prev_out)
    else begin
        error_count++;
        $display("error stable_out: expected %h actual %h",
                 $sampled(prev_out), $sampled(master_out_data));
    end

    remote_state: assert property (@(posedge clk) disable iff (reset)
        master_in_valid && master_in_ready && !master_in_data.is_direct
        |=> remote_root == sent_nbr.root && remote_is_odd == sent_nbr.is_odd_cluster)
    else begin
        error_count++;
        $display("error remote_state: expected %h actual %h",
                 $sampled({sent_nbr.root, sent_nbr.is_odd_cluster}),
                 $sampled({remote_root, remote_is_odd}));
    end

    initial begin
        logic [31:0]  r;
        master_word_t word;
        int           i;
        int           g;
        reset            = 1'b1;
        stage            = IDLE;
        local_root       = '0;
        local_is_odd     = 1'b0;
        increase         = 1'b0;
        direct_in_data   = '0;
        direct_in_valid  = 1'b0;
        master_out_ready = 1'b1;
        master_in_data   = '0;
        master_in_valid  = 1'b0;
        exp_grown        = '0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        check_equal("reset_master_out_valid", 0, master_out_valid);
        check_equal("reset_direct_out_valid", 0, direct_out_valid);
        check_equal("reset_fully_grown", 0, is_fully_grown);
        check_equal("reset_flying", 0, has_message_flying);
        check_equal("reset_in_full", 0, direct_in_is_full);
        check_equal("reset_master_in_ready", 1, master_in_ready);

        // two state changes while the master FIFO stalls
        master_out_ready <= 1'b0;
        local_root <= random_address();
        repeat (3) @(posedge clk);
        local_is_odd <= 1'b1;
        repeat (3) @(posedge clk);
        master_out_ready <= 1'b1;
        wait_drain("neighbor_tx");

        // fill the tx buffer while one neighbor change competes
        master_out_ready <= 1'b0;
        for (i = 0; i < 20 && !direct_in_is_full; i++) begin
            push_direct(random_direct());
            if (i == 4) begin
                local_root <= random_address();
            end
            @(posedge clk);
        end
        check_equal("tx_full", 1, direct_in_is_full);
        master_out_ready <= 1'b1;
        wait_drain("direct_tx");

        for (i = 0; i < 12; i++) begin
            r = $random(seed);
            word.is_direct = r[12];
            word.header    = r[12] ? `ROUTE_ID_DIRECT : `ROUTE_ID_NEIGHBOR;
            word.payload   = r[11:0];
            send_master_word(word);
        end
        wait_drain("receive");

        // growth rounds that each start from a fresh loading stage
        for (i = 0; i < 4; i++) begin
            load_stage();
            wait_drain("grow_clear");
            check_equal("grow_clear", 0, is_fully_grown);
            stage <= GROW;
            repeat (2) @(posedge clk);
            repeat (i) begin
                increase <= 1'b1;
                @(posedge clk);
            end
            increase <= 1'b0;
            exp_grown = (i < `LINK_LENGTH) ? i : `LINK_LENGTH;
            r = $random(seed);
            g = r % 3;
            word.header                     = `ROUTE_ID_NEIGHBOR;
            word.is_direct                  = 1'b0;
            word.payload.nbr.root           = random_address();
            word.payload.nbr.is_odd_cluster = r[4];
            word.payload.nbr.grown          = g;
            send_master_word(word);
            stage <= MERGE;
            wait_drain("grow");
            check_equal("fully_grown", (exp_grown + g >= `LINK_LENGTH), is_fully_grown);
        end

        $display("errors: %0d", error_count);
        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- sources.f
+incdir+rtl
rtl/border_pkg.sv
rtl/neighbor_link_port.sv
rtl/direct_channel_fifo.sv
rtl/master_fifo_arbiter.sv
rtl/partition_border_bridge.sv
tests/tb_border_bridge.sv
